// File: dv/tb_soc_subsys.sv
/*
 * Testbench for the subsystem fabric: clock, reset, xorshift stimulus,
 * address map model, response checker and watchdog
 */

`timescale 1ns/1ps

`include "soc_subsys_config.svh"

module tb_soc_subsys
  import soc_subsys_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int RSP_LATENCY  = 2;
  localparam int DMI_DEL      = `SOC_DMI_DEL_CYCLES;
  localparam int SPM_WORDS    = `SOC_SPM_LEN / 4;

  localparam int N_ROM_RD    = 24;
  localparam int N_ROM_WR    = 8;
  localparam int N_SPM_OPS   = 128;
  localparam int N_UNMAP     = 24;
  localparam int N_CLINT_REQ = 16;
  localparam int MAX_TICKS   = 64;
  localparam int NUM_REQ     = N_ROM_RD + N_ROM_WR + SPM_WORDS + N_SPM_OPS + N_UNMAP
                               + N_CLINT_REQ;
  localparam int RUN_CYCLES  = RESET_CYCLES + DMI_DEL + 16 + 6 * NUM_REQ + 4 * MAX_TICKS;
  localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

  localparam int MAP_ROM   = 0;
  localparam int MAP_SPM   = 1;
  localparam int MAP_CLINT = 2;
  localparam int MAP_NONE  = 3;

  localparam logic [7:0] OFF_MSIP     = 8'h00;
  localparam logic [7:0] OFF_MTIMECMP = 8'h04;
  localparam logic [7:0] OFF_MTIME    = 8'h08;

  logic  clk_i = 1'b0;
  logic  ndmreset_n;
  logic  req_valid_i;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  logic  rsp_valid_o;
  logic  rsp_err_o;
  data_t rsp_rdata_o;
  logic  rtc_tick_i;
  logic  debug_req_i;
  logic  debug_req_o;
  logic  timer_irq_o;
  logic  ipi_o;

  // Model state
  data_t       spm_model [SPM_WORDS];
  logic        msip_model   = 1'b0;
  data_t       mtimecmp_model = '1;
  int          tick_cnt     = 0;
  logic [31:0] rng_state    = 32'd9029;

  // Expected responses in request order
  int    due_q [$];
  logic  err_q [$];
  data_t data_q [$];
  int    pending   = 0;
  int    cycle_cnt = 0;
  string test_name = "init";

  soc_subsys u_soc_subsys (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rtc_tick_i  ( rtc_tick_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("error [%s] %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("[%s] %s", test_name, msg);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic int map_target(input addr_t a);
    if (a >= `SOC_ROM_BASE && a < `SOC_ROM_BASE + `SOC_ROM_LEN) return MAP_ROM;
    if (a >= `SOC_SPM_BASE && a < `SOC_SPM_BASE + `SOC_SPM_LEN) return MAP_SPM;
    if (a >= `SOC_CLINT_BASE && a < `SOC_CLINT_BASE + `SOC_CLINT_LEN) return MAP_CLINT;
    return MAP_NONE;
  endfunction

  // Signature above the word index
  function automatic data_t rom_word(input int k);
    return {`SOC_ROM_SIG, 16'(k)};
  endfunction

  task automatic predict(input logic we, input addr_t addr, input data_t wdata,
                         output logic err, output data_t rdata);
    logic [7:0] off;
    int         idx;
    err   = 1'b0;
    rdata = '0;
    case (map_target(addr))
      MAP_ROM: begin
        if (we) err = 1'b1;
        else rdata = rom_word((addr - `SOC_ROM_BASE) >> 2);
      end
      MAP_SPM: begin
        idx = (addr - `SOC_SPM_BASE) >> 2;
        if (we) spm_model[idx] = wdata;
        else rdata = spm_model[idx];
      end
      MAP_CLINT: begin
        off = 8'(addr - `SOC_CLINT_BASE);
        if (we) begin
          if (off == OFF_MSIP) msip_model = wdata[0];
          if (off == OFF_MTIMECMP) mtimecmp_model = wdata;
        end else if (off == OFF_MSIP) begin
          rdata = {31'b0, msip_model};
        end else if (off == OFF_MTIMECMP) begin
          rdata = mtimecmp_model;
        end else if (off == OFF_MTIME) begin
          rdata = data_t'(tick_cnt / 2);
        end
      end
      default: err = 1'b1;
    endcase
  endtask

  task automatic send(input logic we, input addr_t addr, input data_t wdata);
    logic  err;
    data_t rdata;
    @(posedge clk_i);
    predict(we, addr, wdata, err, rdata);
    // One edge for the DUT to sample, then the pipeline latency
    due_q.push_back(cycle_cnt + 1 + RSP_LATENCY);
    err_q.push_back(err);
    data_q.push_back(rdata);
    pending++;
    req_valid_i <= 1'b1;
    req_we_i    <= we;
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
  endtask

  task automatic drain();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    req_we_i    <= 1'b0;
    wait (pending == 0);
    @(posedge clk_i);
  endtask

  task automatic drive_ticks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      rtc_tick_i <= 1'b1;
      tick_cnt++;
      @(posedge clk_i);
      rtc_tick_i <= 1'b0;
      repeat (next_rand() % 3) @(posedge clk_i);
    end
  endtask

  // --------------------------------------------------
  // Response checker
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (ndmreset_n) begin
      if (rsp_valid_o) begin
        check_true(pending > 0, "Response seen with no request outstanding");
        check_value("rsp cycle", due_q[0], cycle_cnt);
        check_value("rsp_err_o", {31'b0, err_q[0]}, {31'b0, rsp_err_o});
        check_value("rsp_rdata_o", data_q[0], rsp_rdata_o);
        void'(due_q.pop_front());
        void'(err_q.pop_front());
        void'(data_q.pop_front());
        pending--;
      end else if (pending > 0) begin
        check_true(due_q[0] > cycle_cnt, "Response missing at its expected cycle");
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
    $display("Test FAILED");
    $fatal(1);
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] r;
    addr_t       a;
    data_t       mtime_now;
    ndmreset_n  = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rtc_tick_i  = 1'b0;
    debug_req_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    ndmreset_n  <= 1'b1;
    debug_req_i <= 1'b1;

    test_name = "reset";
    for (int i = 1; i <= DMI_DEL; i++) begin
      @(posedge clk_i);
      if (i == 1) begin
        check_value("rsp_valid_o", 0, rsp_valid_o);
        check_value("timer_irq_o", 0, timer_irq_o);
        check_value("ipi_o", 0, ipi_o);
      end
      check_value("debug_req_o gated", 0, debug_req_o);
    end
    @(posedge clk_i);
    check_value("debug_req_o open", 1, debug_req_o);
    debug_req_i <= 1'b0;
    @(posedge clk_i);
    check_value("debug_req_o follows", 0, debug_req_o);

    test_name = "rom";
    for (int i = 0; i < N_ROM_RD; i++) send(1'b0, `SOC_ROM_BASE + ((next_rand() % 16) << 2), '0);
    for (int i = 0; i < N_ROM_WR; i++) begin
      send(1'b1, `SOC_ROM_BASE + ((next_rand() % 16) << 2), next_rand());
    end
    drain();

    test_name = "spm";
    for (int i = 0; i < SPM_WORDS; i++) send(1'b1, `SOC_SPM_BASE + (i << 2), next_rand());
    for (int i = 0; i < N_SPM_OPS; i++) begin
      r = next_rand();
      send(r[0], `SOC_SPM_BASE + (((r >> 8) % SPM_WORDS) << 2), next_rand());
    end
    drain();

    test_name = "unmapped";
    send(1'b0, `SOC_ROM_BASE - 4, '0);
    send(1'b0, `SOC_ROM_BASE + `SOC_ROM_LEN, '0);
    send(1'b1, `SOC_SPM_BASE + `SOC_SPM_LEN, next_rand());
    send(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_LEN, '0);
    for (int i = 0; i < N_UNMAP; i++) begin
      do a = next_rand(); while (map_target(a) != MAP_NONE);
      r = next_rand();
      send(r[0], a, next_rand());
    end
    drain();

    test_name = "clint";
    drive_ticks(8 + next_rand() % (MAX_TICKS - 8));
    send(1'b0, `SOC_CLINT_BASE + OFF_MTIME, '0);
    send(1'b0, `SOC_CLINT_BASE + OFF_MTIMECMP, '0);
    send(1'b0, `SOC_CLINT_BASE + 8'h0C, '0);
    drain();
    mtime_now = data_t'(tick_cnt / 2);
    send(1'b1, `SOC_CLINT_BASE + OFF_MTIMECMP, mtime_now - 1);
    drain();
    check_value("timer_irq_o raised", 1, timer_irq_o);
    send(1'b1, `SOC_CLINT_BASE + OFF_MTIMECMP, mtime_now + 1 + next_rand() % 100);
    send(1'b0, `SOC_CLINT_BASE + OFF_MTIMECMP, '0);
    drain();
    check_value("timer_irq_o lowered", 0, timer_irq_o);
    send(1'b1, `SOC_CLINT_BASE + OFF_MSIP, next_rand() | 32'h1);
    send(1'b0, `SOC_CLINT_BASE + OFF_MSIP, '0);
    drain();
    check_value("ipi_o set", 1, ipi_o);
    send(1'b1, `SOC_CLINT_BASE + OFF_MSIP, next_rand() & ~32'h1);
    send(1'b0, `SOC_CLINT_BASE + OFF_MSIP, '0);
    drain();
    check_value("ipi_o cleared", 0, ipi_o);
    send(1'b1, `SOC_CLINT_BASE + OFF_MTIME, next_rand());
    send(1'b0, `SOC_CLINT_BASE + OFF_MTIME, '0);
    drain();

    $display("Test OK");
    $finish;
  end

endmodule

// File: rtl/soc_addr_decode.sv
/*
 * Stage 1 of the fabric: samples a request, matches it against
 * the address rule table and registers target, offset and data
 */

`timescale 1ns/1ps

`include "soc_subsys_config.svh"

module soc_addr_decode
  import soc_subsys_pkg::*;
(
  input  logic         clk_i,
  input  logic         ndmreset_n,
  input  logic         req_valid_i,
  input  logic         req_we_i,
  input  addr_t        req_addr_i,
  input  data_t        req_wdata_i,
  soc_bus_if.dec       bus_o
);

  localparam int NUM_RULES = 3;

  // Rule index equals the target encoding
  localparam addr_t RULE_BASE [NUM_RULES] = '{
    `SOC_ROM_BASE,
    `SOC_SPM_BASE,
    `SOC_CLINT_BASE
  };

  localparam addr_t RULE_LEN [NUM_RULES] = '{
    `SOC_ROM_LEN,
    `SOC_SPM_LEN,
    `SOC_CLINT_LEN
  };

  target_e hit_tgt;
  off_t    hit_off;

  logic    valid_q;
  logic    we_q;
  target_e target_q;
  off_t    off_q;
  data_t   wdata_q;

  // --------------------------------------------------
  // Rule match
  // --------------------------------------------------
  always_comb begin
    hit_tgt = TGT_NONE;
    hit_off = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (req_addr_i >= RULE_BASE[i] && req_addr_i < RULE_BASE[i] + RULE_LEN[i]) begin
        hit_tgt = target_e'(i);
        hit_off = off_t'(req_addr_i - RULE_BASE[i]);
      end
    end
    // ROM is read only
    if (hit_tgt == TGT_ROM && req_we_i) begin
      hit_tgt = TGT_NONE;
    end
  end

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      we_q     <= req_we_i;
      target_q <= hit_tgt;
      off_q    <= hit_off;
      wdata_q  <= req_wdata_i;
    end
  end

  assign bus_o.valid  = valid_q;
  assign bus_o.we     = we_q;
  assign bus_o.target = target_q;
  assign bus_o.off    = off_q;
  assign bus_o.wdata  = wdata_q;

endmodule

// File: rtl/soc_bus_if.sv
/*
 * Decoded request bus from the decode stage to the access stage
 */

`timescale 1ns/1ps

interface soc_bus_if
  import soc_subsys_pkg::*;
();

  logic    valid;
  logic    we;
  target_e target;
  off_t    off;
  data_t   wdata;

  modport dec (
    output valid,
    output we,
    output target,
    output off,
    output wdata
  );

  modport acc (
    input valid,
    input we,
    input target,
    input off,
    input wdata
  );

endinterface

// File: rtl/soc_clint.sv
/*
 * CLINT with mtime, mtimecmp and msip, timer and software
 * interrupts, and the post-reset debug-request gate
 */

`timescale 1ns/1ps

`include "soc_subsys_config.svh"

module soc_clint
  import soc_subsys_pkg::*;
(
  input  logic         clk_i,
  input  logic         ndmreset_n,
  input  logic         rtc_tick_i,
  input  logic         debug_req_i,
  soc_reg_if.dev       reg_i,
  output logic         timer_irq_o,
  output logic         ipi_o,
  output logic         debug_req_o
);

  localparam int DEL_W = $clog2(`SOC_DMI_DEL_CYCLES + 1);

  logic   tick_half_q;
  mtime_t mtime_q;
  mtime_t mtimecmp_q;
  logic   msip_q;
  logic   timer_irq_q;

  logic [DEL_W-1:0] dmi_del_cnt_q;

  // --------------------------------------------------
  // Timer
  // --------------------------------------------------
  // RTC ticks halved, mtime steps on every second one
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      tick_half_q <= 1'b0;
      mtime_q     <= '0;
    end else if (rtc_tick_i) begin
      tick_half_q <= ~tick_half_q;
      if (tick_half_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // Register writes, MTIME is read only here
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else if (reg_i.req && reg_i.we) begin
      case (reg_i.off)
        MSIP:     msip_q     <= reg_i.wdata[0];
        MTIMECMP: mtimecmp_q <= reg_i.wdata;
        default:  ;
      endcase
    end
  end

  always_comb begin
    case (reg_i.off)
      MSIP:     reg_i.rdata = {{(`SOC_DATA_W-1){1'b0}}, msip_q};
      MTIMECMP: reg_i.rdata = mtimecmp_q;
      MTIME:    reg_i.rdata = mtime_q;
      default:  reg_i.rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // --------------------------------------------------
  // Debug request gate
  // --------------------------------------------------
  // Lets boot code run before the first debug request
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dmi_del_cnt_q <= DEL_W'(`SOC_DMI_DEL_CYCLES);
    end else if (dmi_del_cnt_q != '0) begin
      dmi_del_cnt_q <= dmi_del_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dmi_del_cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

// File: rtl/soc_reg_if.sv
/*
 * Register port from the access stage to the CLINT
 */

`timescale 1ns/1ps

interface soc_reg_if
  import soc_subsys_pkg::*;
();

  logic  req;
  logic  we;
  off_t  off;
  data_t wdata;
  // Combinational read data, selected by off
  data_t rdata;

  modport host (output req, output we, output off, output wdata, input rdata);

  modport dev (input req, input we, input off, input wdata, output rdata);

endinterface

// File: rtl/soc_subsys.sv
/*
 * Subsystem top: decode stage, access stage and CLINT
 */

`timescale 1ns/1ps

module soc_subsys
  import soc_subsys_pkg::*;
(
  input  logic  clk_i,
  input  logic  ndmreset_n,
  // Request
  input  logic  req_valid_i,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  // Response, two cycles after the request
  output logic  rsp_valid_o,
  output logic  rsp_err_o,
  output data_t rsp_rdata_o,
  input  logic  rtc_tick_i,
  input  logic  debug_req_i,
  output logic  debug_req_o,
  output logic  timer_irq_o,
  output logic  ipi_o
);

  soc_bus_if u_bus ();
  soc_reg_if u_reg ();

  soc_addr_decode u_addr_decode (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .bus_o       ( u_bus.dec   )
  );

  soc_target_access u_target_access (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus_i       ( u_bus.acc   ),
    .clint_o     ( u_reg.host  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o )
  );

  soc_clint u_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_tick_i  ( rtc_tick_i  ),
    .debug_req_i ( debug_req_i ),
    .reg_i       ( u_reg.dev   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: rtl/soc_subsys_config.svh
/*
 * Bus widths, address map rules (base and length per target),
 * boot ROM signature and debug-request gate length
 */

`ifndef SOC_SUBSYS_CONFIG_SVH
`define SOC_SUBSYS_CONFIG_SVH

// Bus widths
`define SOC_ADDR_W         32
`define SOC_DATA_W         32
`define SOC_OFF_W          8

// --------------------------------------------------
// Address map
// --------------------------------------------------
`define SOC_ROM_BASE       32'h0001_0000
`define SOC_ROM_LEN        32'h0000_0040
`define SOC_SPM_BASE       32'h1C00_0000
`define SOC_SPM_LEN        32'h0000_0100
`define SOC_CLINT_BASE     32'h0200_0000
`define SOC_CLINT_LEN      32'h0000_0010

// Upper half of every boot ROM word
`define SOC_ROM_SIG        16'hB007

// Cycles after reset before debug requests pass
`define SOC_DMI_DEL_CYCLES 500

`endif

// File: rtl/soc_subsys_pkg.sv
/*
 * Shared types of the subsystem: address, data, offset and
 * timer vectors, the target select and the CLINT register map
 */

`include "soc_subsys_config.svh"

package soc_subsys_pkg;

  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  // Byte offset inside one target window
  typedef logic [`SOC_OFF_W-1:0]  off_t;

  // mtime and mtimecmp
  typedef logic [`SOC_DATA_W-1:0] mtime_t;

  // Target picked by the address map, TGT_NONE answers with an error
  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_SPM   = 2'd1,
    TGT_CLINT = 2'd2,
    TGT_NONE  = 2'd3
  } target_e;

  // CLINT register offsets
  typedef enum logic [`SOC_OFF_W-1:0] {
    MSIP     = 8'h00,
    MTIMECMP = 8'h04,
    MTIME    = 8'h08
  } clint_off_e;

endpackage

// File: rtl/soc_target_access.sv
/*
 * Stage 2 of the fabric: boot ROM, L2 scratchpad, CLINT register
 * port and the registered response
 */

`timescale 1ns/1ps

`include "soc_subsys_config.svh"

module soc_target_access
  import soc_subsys_pkg::*;
(
  input  logic         clk_i,
  input  logic         ndmreset_n,
  soc_bus_if.acc       bus_i,
  soc_reg_if.host      clint_o,
  output logic         rsp_valid_o,
  output logic         rsp_err_o,
  output data_t        rsp_rdata_o
);

  localparam int ROM_WORDS  = `SOC_ROM_LEN / 4;
  localparam int SPM_WORDS  = `SOC_SPM_LEN / 4;
  localparam int ROM_IDX_W  = $clog2(ROM_WORDS);
  localparam int SPM_IDX_W  = $clog2(SPM_WORDS);
  localparam int HALF_W     = `SOC_DATA_W / 2;

  localparam logic [HALF_W-1:0] ROM_SIG_HI = `SOC_ROM_SIG;

  logic [ROM_IDX_W-1:0] rom_idx;
  logic [SPM_IDX_W-1:0] spm_idx;
  data_t                rom_rdata;
  logic                 spm_we;

  data_t spm_mem [SPM_WORDS];

  data_t rdata_d;
  logic  err_d;

  logic  rsp_valid_q;
  logic  rsp_err_q;
  data_t rsp_rdata_q;

  // Word index inside each window
  assign rom_idx = bus_i.off[ROM_IDX_W+1:2];
  assign spm_idx = bus_i.off[SPM_IDX_W+1:2];

  // --------------------------------------------------
  // Boot ROM
  // --------------------------------------------------
  // Word k holds the signature above k
  assign rom_rdata = {ROM_SIG_HI, {(HALF_W-ROM_IDX_W){1'b0}}, rom_idx};

  // --------------------------------------------------
  // L2 scratchpad
  // --------------------------------------------------
  assign spm_we = bus_i.valid && bus_i.we && (bus_i.target == TGT_SPM);

  always_ff @(posedge clk_i) begin
    if (spm_we) begin
      spm_mem[spm_idx] <= bus_i.wdata;
    end
  end

  // CLINT register port
  assign clint_o.req   = bus_i.valid && (bus_i.target == TGT_CLINT);
  assign clint_o.we    = bus_i.we;
  assign clint_o.off   = bus_i.off;
  assign clint_o.wdata = bus_i.wdata;

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  always_comb begin
    case (bus_i.target)
      TGT_ROM:   rdata_d = rom_rdata;
      TGT_SPM:   rdata_d = spm_mem[spm_idx];
      TGT_CLINT: rdata_d = clint_o.rdata;
      default:   rdata_d = '0;
    endcase
    // Writes answer with zero data
    if (bus_i.we) begin
      rdata_d = '0;
    end
  end

  assign err_d = (bus_i.target == TGT_NONE);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= bus_i.valid;
      rsp_err_q   <= bus_i.valid && err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.valid) begin
      rsp_rdata_q <= rdata_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_rdata_o = rsp_rdata_q;

endmodule

// File: soc_subsys.f
+incdir+rtl
rtl/soc_subsys_pkg.sv
rtl/soc_bus_if.sv
rtl/soc_reg_if.sv
rtl/soc_addr_decode.sv
rtl/soc_target_access.sv
rtl/soc_clint.sv
rtl/soc_subsys.sv
dv/tb_soc_subsys.sv
